// ==== hw/sample_pkg.sv ====
package sample_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sample stream
    ////////////////////////////////////////////////////////////////////////////

    // ADC word width
    localparam int SAMPLE_W = 8;

    // One raw sample
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Full scale, the ceiling for the high threshold
    localparam sample_t SAMPLE_MAX = '1;

    // Incoming stream word, valid strobe plus data
    typedef struct packed {
        logic    valid;
        sample_t data;
    } sample_beat_t;

    ////////////////////////////////////////////////////////////////////////////
    // Capture buffer geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int BUF_DEPTH = 256;
    localparam int BUF_AW    = 8;

    // Address, or a count that wraps with the buffer
    typedef logic [BUF_AW-1:0] buf_addr_t;

endpackage

// ==== hw/trig_pkg.sv ====
package trig_pkg;

    import sample_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Trigger configuration
    ////////////////////////////////////////////////////////////////////////////

    // Encoding width of the mode field
    localparam int TRIG_MODE_W = 2;

    // Trigger kinds
    // Edge modes use hysteresis, level mode ignores it
    typedef enum logic [TRIG_MODE_W-1:0] {
        TRIG_RISE  = 2'd0,
        TRIG_FALL  = 2'd1,
        TRIG_LEVEL = 2'd2
    } trig_mode_e;

    // Held stable by the user from arm until done
    typedef struct packed {
        trig_mode_e mode;
        // Trigger level
        sample_t    level;
        // Half-width of the hysteresis band around level
        sample_t    hyst;
    } trig_cfg_t;

endpackage

// ==== hw/trigger_detect.sv ====
`timescale 1ns/1ns

module trigger_detect
    import sample_pkg::*, trig_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         arm,
    input  sample_beat_t sample_in,
    input  trig_cfg_t    cfg,
    output logic         fire
);

    ////////////////////////////////////////////////////////////////////////////
    // Thresholds
    ////////////////////////////////////////////////////////////////////////////

    // One extra bit to catch the carry out of level + hyst
    logic [SAMPLE_W:0] hi_sum;
    sample_t           thr_hi;
    sample_t           thr_lo;

    // Compare results for the current sample
    logic              at_hi;
    logic              at_lo;
    logic              at_level;

    // Set by a full excursion to the opposite side of the band
    logic              armed;

    assign hi_sum = {1'b0, cfg.level} + {1'b0, cfg.hyst};

    // Saturate at full scale
    assign thr_hi = hi_sum[SAMPLE_W] ? SAMPLE_MAX : hi_sum[SAMPLE_W-1:0];

    // Saturate at zero
    assign thr_lo = (cfg.level > cfg.hyst) ? (cfg.level - cfg.hyst) : '0;

    assign at_hi    = (sample_in.data >= thr_hi);
    assign at_lo    = (sample_in.data <= thr_lo);
    assign at_level = (sample_in.data >= cfg.level);

    ////////////////////////////////////////////////////////////////////////////
    // Fire decision, same cycle as the sample
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        fire = 1'b0;
        if (sample_in.valid) begin
            case (cfg.mode)
                TRIG_RISE:  fire = armed && at_hi;
                TRIG_FALL:  fire = armed && at_lo;
                TRIG_LEVEL: fire = at_level;
                default:    fire = 1'b0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hysteresis state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            armed <= 1'b0;
        end else if (arm) begin
            // New capture starts without history
            armed <= 1'b0;
        end else if (sample_in.valid) begin
            case (cfg.mode)
                TRIG_RISE: begin
                    // Must dip below the band before the next rise counts
                    if (fire) begin
                        armed <= 1'b0;
                    end else if (at_lo) begin
                        armed <= 1'b1;
                    end
                end
                TRIG_FALL: begin
                    // Mirror image, must climb above the band first
                    if (fire) begin
                        armed <= 1'b0;
                    end else if (at_hi) begin
                        armed <= 1'b1;
                    end
                end
                default: armed <= 1'b0;
            endcase
        end
    end

    // A pulse on an empty stream slot would be a phantom trigger
    a_fire_needs_valid: assert property (
        @(posedge clk) disable iff (!rst) fire |-> sample_in.valid
    );

endmodule

// ==== hw/capture_ctrl.sv ====
`timescale 1ns/1ns

module capture_ctrl
    import sample_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         arm,
    input  logic         fire,
    input  logic         rd_en,
    input  sample_beat_t sample_in,
    input  buf_addr_t    pre_len,
    input  buf_addr_t    rd_index,
    output logic         wr_en,
    output buf_addr_t    wr_addr,
    output buf_addr_t    rd_addr,
    output sample_t      wr_data,
    output logic         done,
    output logic         triggered
);

    // Capture phases
    // Done is not a state of its own, it is the done flag while in IDLE
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        WAIT_TRIG,
        POST
    } cap_state_e;

    cap_state_e state;

    // Next write location
    buf_addr_t  wr_ptr;
    // Samples written since arm, FILL only
    buf_addr_t  pre_cnt;
    // Samples written after the trigger sample
    buf_addr_t  post_cnt;
    // Where the trigger sample landed
    buf_addr_t  trig_addr;
    // Samples still owed after the trigger sample
    buf_addr_t  post_len;

    assign post_len = buf_addr_t'(BUF_DEPTH - 1) - pre_len;

    ////////////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////////////

    // Arm cycle sample is dropped, capture begins on the next one
    assign wr_en   = sample_in.valid && !arm && (state != IDLE);
    assign wr_addr = wr_ptr;
    assign wr_data = sample_in.data;

    ////////////////////////////////////////////////////////////////////////////
    // Capture FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= IDLE;
            wr_ptr    <= '0;
            pre_cnt   <= '0;
            post_cnt  <= '0;
            done      <= 1'b0;
            triggered <= 1'b0;
        end else if (arm) begin
            // Restart from address zero, whatever the current phase
            state     <= (pre_len == '0) ? WAIT_TRIG : FILL;
            wr_ptr    <= '0;
            pre_cnt   <= '0;
            post_cnt  <= '0;
            done      <= 1'b0;
            triggered <= 1'b0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
            case (state)
                FILL: begin
                    // Fire ignored here, the window is not full yet
                    pre_cnt <= pre_cnt + 1'b1;
                    if (pre_cnt + 1'b1 == pre_len) begin
                        state <= WAIT_TRIG;
                    end
                end
                WAIT_TRIG: begin
                    // Keeps overwriting the oldest pre-trigger samples
                    if (fire) begin
                        triggered <= 1'b1;
                        post_cnt  <= '0;
                        if (post_len == '0) begin
                            // Trigger sample was the last one
                            done  <= 1'b1;
                            state <= IDLE;
                        end else begin
                            state <= POST;
                        end
                    end
                end
                POST: begin
                    post_cnt <= post_cnt + 1'b1;
                    if (post_cnt + 1'b1 == post_len) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Trigger location, no reset needed
    always_ff @(posedge clk) begin
        if (!arm && wr_en && state == WAIT_TRIG && fire) begin
            trig_addr <= wr_ptr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readout mapping
    ////////////////////////////////////////////////////////////////////////////

    // Index zero is the oldest sample, pre_len slots before the trigger
    assign rd_addr = trig_addr - pre_len + rd_index;

    // A finished window must never be overwritten
    a_no_write_when_done: assert property (
        @(posedge clk) disable iff (!rst) done |-> !wr_en
    );

    // Readout only of a completed capture
    a_read_only_when_done: assert property (
        @(posedge clk) disable iff (!rst) rd_en |-> done
    );

endmodule

// ==== hw/sample_ram.sv ====
`timescale 1ns/1ns

module sample_ram
    import sample_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  logic      rd_en,
    input  buf_addr_t wr_addr,
    input  buf_addr_t rd_addr,
    input  sample_t   wr_data,
    output sample_t   rd_data,
    output logic      rd_valid
);

    // Circular capture buffer
    sample_t mem [BUF_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Array ports
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // Write side, one sample per cycle
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // Read side, data out one cycle after the strobe
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Strobe follows the data by the same one cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

// ==== hw/scope_capture.sv ====
`timescale 1ns/1ns

module scope_capture
    import sample_pkg::*, trig_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  sample_beat_t sample_in,
    input  trig_cfg_t    trig_cfg,
    input  buf_addr_t    pre_len,
    input  logic         arm,
    input  logic         rd_en,
    input  buf_addr_t    rd_index,
    output logic         done,
    output logic         triggered,
    output sample_t      rd_data,
    output logic         rd_valid
);

    // Trigger pulse, same cycle as its sample
    logic      fire;

    // Memory write port
    logic      wr_en;
    buf_addr_t wr_addr;
    sample_t   wr_data;

    // Physical read location
    buf_addr_t rd_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Trigger, controller, buffer
    ////////////////////////////////////////////////////////////////////////////

    trigger_detect u_trig (
        .clk       (clk),
        .rst       (rst),
        .arm       (arm),
        .sample_in (sample_in),
        .cfg       (trig_cfg),
        .fire      (fire)
    );

    capture_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .arm       (arm),
        .fire      (fire),
        .rd_en     (rd_en),
        .sample_in (sample_in),
        .pre_len   (pre_len),
        .rd_index  (rd_index),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .rd_addr   (rd_addr),
        .wr_data   (wr_data),
        .done      (done),
        .triggered (triggered)
    );

    // Read strobe goes straight to the array
    sample_ram u_ram (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .wr_addr  (wr_addr),
        .rd_addr  (rd_addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

// ==== bench/scope_capture_tb.sv ====
`timescale 1ns/1ns

module scope_capture_tb
    import sample_pkg::*, trig_pkg::*;
();

    // Waveform kinds of the stimulus table
    localparam logic [1:0] WAVE_TRI   = 2'd0;
    localparam logic [1:0] WAVE_NOISY = 2'd1;
    localparam logic [1:0] WAVE_CONST = 2'd2;
    localparam logic [1:0] WAVE_STAIR = 2'd3;

    localparam int N_CASES      = 7;
    localparam int STREAM_LIMIT = 4000;
    localparam int QUIET_LIMIT  = 1500;

    // One row of the stimulus table
    typedef struct packed {
        trig_mode_e mode;
        sample_t    level;
        sample_t    hyst;
        buf_addr_t  pre_len;
        logic [1:0] kind;
        sample_t    amp;
        sample_t    period;
        sample_t    noise;
        logic       rearm;
    } case_t;

    logic         clk;
    logic         rst;
    sample_beat_t sample_in;
    trig_cfg_t    trig_cfg;
    buf_addr_t    pre_len;
    logic         arm;
    logic         rd_en;
    buf_addr_t    rd_index;
    logic         done;
    logic         triggered;
    sample_t      rd_data;
    logic         rd_valid;

    case_t        cases [N_CASES];
    logic [15:0]  lfsr;

    // Reference model, valid samples since the last arm
    sample_t      model_mem [4096];
    int           m_cnt;
    int           m_trig_idx;
    logic         m_armed;
    logic         m_trig;
    logic         m_done;

    scope_capture UUT (
        .clk       (clk),
        .rst       (rst),
        .sample_in (sample_in),
        .trig_cfg  (trig_cfg),
        .pre_len   (pre_len),
        .arm       (arm),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .done      (done),
        .triggered (triggered),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random bits and waveforms
    ////////////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One step per bit taken
    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic sample_t wave_value(input case_t c, input int i, input int noise);
        int amp;
        int per;
        int ph;
        int v;
        amp = int'(c.amp);
        per = int'(c.period);
        ph  = i % per;
        case (c.kind)
            WAVE_CONST: v = amp;
            WAVE_STAIR: v = ((i / per) * amp) % 256;
            default: begin
                // Triangle centred on mid scale
                v = (ph < per / 2) ? amp * ph / (per / 2) : amp * (per - ph) / (per / 2);
                v = v + 128 - amp / 2 + noise;
            end
        endcase
        v = (v < 0) ? 0 : v;
        v = (v > 255) ? 255 : v;
        return sample_t'(v);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of trigger and capture
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_sample(input case_t c, input sample_t s);
        int   hi;
        int   lo;
        logic f;
        hi = int'(c.level) + int'(c.hyst);
        lo = int'(c.level) - int'(c.hyst);
        hi = (hi > 255) ? 255 : hi;
        lo = (lo < 0) ? 0 : lo;
        case (c.mode)
            TRIG_RISE: f = m_armed && (int'(s) >= hi);
            TRIG_FALL: f = m_armed && (int'(s) <= lo);
            default:   f = (s >= c.level);
        endcase
        // Edge modes need a full excursion before the next fire
        if (c.mode == TRIG_RISE) begin
            m_armed = f ? 1'b0 : (m_armed || int'(s) <= lo);
        end else if (c.mode == TRIG_FALL) begin
            m_armed = f ? 1'b0 : (m_armed || int'(s) >= hi);
        end
        model_mem[m_cnt] = s;
        // Fire counts only once pre_len samples are in
        if (!m_trig && f && m_cnt >= int'(c.pre_len)) begin
            m_trig     = 1'b1;
            m_trig_idx = m_cnt;
        end
        m_cnt++;
        m_done = m_trig && (m_cnt == m_trig_idx + 256 - int'(c.pre_len));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Capture sequences
    ////////////////////////////////////////////////////////////////////////////

    // Arm cycle carries no sample
    task automatic pulse_arm();
        arm             = 1'b1;
        sample_in.valid = 1'b0;
        @(posedge clk);
        #2;
        arm        = 1'b0;
        m_cnt      = 0;
        m_trig     = 1'b0;
        m_done     = 1'b0;
        m_armed    = 1'b0;
    endtask

    // Two cycles per index, data one cycle after the strobe
    task automatic read_window(input case_t c);
        int base;
        base = m_trig_idx - int'(c.pre_len);
        for (int k = 0; k < BUF_DEPTH; k++) begin
            rd_en    = 1'b1;
            rd_index = buf_addr_t'(k);
            @(posedge clk);
            #2;
            rd_en    = 1'b0;
            // Registered word must hold while the index moves on
            rd_index = buf_addr_t'(k + 128);
            check_flag(rd_valid, 1'b1, "rd_valid");
            check_sample(rd_data, model_mem[base + k], "rd_data");
            @(posedge clk);
            #2;
            // Valid is a one-cycle pulse
            check_flag(rd_valid, 1'b0, "rd_valid after strobe");
        end
    endtask

    task automatic run_case(input int n, input case_t c);
        int   cycles;
        int   limit;
        int   tick;
        int   r;
        int   noise;
        int   post_len;
        logic rearmed;
        logic stop;
        trig_cfg = '{mode: c.mode, level: c.level, hyst: c.hyst};
        pre_len  = c.pre_len;
        post_len = 255 - int'(c.pre_len);
        limit    = (c.kind == WAVE_CONST) ? QUIET_LIMIT : STREAM_LIMIT;
        cycles   = 0;
        tick     = 0;
        rearmed  = 1'b0;
        stop     = 1'b0;
        pulse_arm();
        while (!stop) begin
            check_flag(triggered, m_trig, "triggered");
            check_flag(done, m_done, "done");
            if (m_done) begin
                stop = 1'b1;
            end else if (cycles == limit) begin
                // A flat signal is expected to sit here with nothing captured
                if (c.kind == WAVE_CONST) begin
                    stop = 1'b1;
                end else begin
                    $display("Timeout: done never rose within %0d cycles in case %0d", limit, n);
                    $display("Simulation failed");
                    $fatal(1, "capture timeout");
                end
            end else if (c.rearm && !rearmed && m_trig
                         && (m_cnt - m_trig_idx - 1 == post_len / 2)) begin
                // Restart halfway through the post-trigger phase
                rearmed = 1'b1;
                cycles++;
                pulse_arm();
            end else begin
                cycles++;
                take_bits(1, r);
                noise = 0;
                if (c.kind == WAVE_NOISY) begin
                    take_bits(6, noise);
                    noise = noise % (2 * int'(c.noise) + 1) - int'(c.noise);
                end
                sample_in.valid = r[0];
                sample_in.data  = wave_value(c, tick, noise);
                if (r[0]) begin
                    model_sample(c, sample_in.data);
                end
                tick++;
                @(posedge clk);
                #2;
            end
        end
        sample_in.valid = 1'b0;
        if (m_done) begin
            read_window(c);
        end
    endtask

    initial begin
        rst       = 1'b0;
        arm       = 1'b0;
        rd_en     = 1'b0;
        rd_index  = '0;
        sample_in = '0;
        trig_cfg  = '0;
        pre_len   = '0;
        lfsr      = 16'd94;
        // mode level hyst pre_len kind amp period noise rearm
        cases[0] = '{TRIG_RISE,  8'd128, 8'd20, 8'd100, WAVE_NOISY, 8'd200, 8'd64, 8'd6,  1'b0};
        cases[1] = '{TRIG_FALL,  8'd100, 8'd10, 8'd64,  WAVE_TRI,   8'd180, 8'd50, 8'd0,  1'b0};
        cases[2] = '{TRIG_LEVEL, 8'd200, 8'd0,  8'd0,   WAVE_STAIR, 8'd16,  8'd7,  8'd0,  1'b0};
        cases[3] = '{TRIG_LEVEL, 8'd60,  8'd0,  8'd255, WAVE_STAIR, 8'd9,   8'd5,  8'd0,  1'b0};
        cases[4] = '{TRIG_RISE,  8'd128, 8'd8,  8'd32,  WAVE_CONST, 8'd10,  8'd16, 8'd0,  1'b0};
        cases[5] = '{TRIG_RISE,  8'd150, 8'd12, 8'd128, WAVE_TRI,   8'd220, 8'd40, 8'd0,  1'b1};
        cases[6] = '{TRIG_FALL,  8'd90,  8'd30, 8'd200, WAVE_NOISY, 8'd240, 8'd90, 8'd20, 1'b1};
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;
        check_flag(done, 1'b0, "done after reset");
        check_flag(triggered, 1'b0, "triggered after reset");
        check_flag(rd_valid, 1'b0, "rd_valid after reset");
        for (int n = 0; n < N_CASES; n++) begin
            run_case(n, cases[n]);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== src.f ====
hw/sample_pkg.sv
hw/trig_pkg.sv
hw/trigger_detect.sv
hw/capture_ctrl.sv
hw/sample_ram.sv
hw/scope_capture.sv
bench/scope_capture_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the bench with Verilator, run it, and judge the run by its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module scope_capture_tb -f src.f \
    && out=$(./obj_dir/Vscope_capture_tb 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }
